// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_ethRx
FILELIST  := tb.f
OBJDIR    := obj_dir
FLAGS     := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJDIR)
BIN       := $(OBJDIR)/V$(TOP)
SOURCES   := $(wildcard *.sv *.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)

// ==== ethRxParser.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ethRx_consts.svh"

module ethRxParser (
  input  logic                 RxClk,
  input  logic                 reset,
  input  logic                 portActive,
  input  logic                 RxValid,
  input  ethRx_pkg::byte_t     RxD,
  input  logic                 RxErr,
  output ethRx_pkg::frameHdr_t hdr,
  output logic                 hdrDone,
  output ethRx_pkg::byte_t     dataByte,
  output logic                 dataValid,
  output logic                 frameEnd,
  output logic                 rxErrSeen
);

  localparam int ShiftW = (`ETH_HDR_LEN - 1) * 8;   // All but the last header byte
  localparam logic [3:0] HdrLast = 4'(`ETH_HDR_LEN - 1);

  ethRx_pkg::rxState_t state;
  logic [3:0]          hdrCnt;      // Header byte index
  logic [ShiftW-1:0]   hdrShift;    // Header bytes collected so far
  logic                hdrLast;     // Last header byte on RxD now

  assign hdrLast = portActive && (state == ethRx_pkg::Header) && RxValid &&
                   (hdrCnt == HdrLast);

  always_ff @(posedge RxClk) begin
    hdrDone   <= 1'b0;    // Pulses by default
    frameEnd  <= 1'b0;
    dataValid <= 1'b0;
    if (reset || !portActive) begin
      state     <= ethRx_pkg::Idle;
      hdrCnt    <= '0;
      rxErrSeen <= 1'b0;
    end else begin
      case (state)
        ethRx_pkg::Idle: begin
          // Preamble bytes are not checked, only the SFD
          if (RxValid && (RxD == `ETH_SFD)) begin
            state     <= ethRx_pkg::Header;
            hdrCnt    <= '0;
            rxErrSeen <= 1'b0;   // New frame
          end
        end
        ethRx_pkg::Header: begin
          if (!RxValid) begin
            state <= ethRx_pkg::Idle;   // Runt, drop silently
          end else begin
            hdrCnt <= hdrCnt + 4'd1;
            if (RxErr)
              rxErrSeen <= 1'b1;
            if (hdrLast) begin
              hdrDone <= 1'b1;
              state   <= ethRx_pkg::Data;
            end
          end
        end
        ethRx_pkg::Data: begin
          if (RxValid) begin
            dataValid <= 1'b1;
            if (RxErr)
              rxErrSeen <= 1'b1;
          end else begin
            frameEnd <= 1'b1;             // First idle cycle ends the frame
            state    <= ethRx_pkg::Idle;
          end
        end
        default: state <= ethRx_pkg::Idle;
      endcase
    end
  end

  // Header and payload bytes
  always_ff @(posedge RxClk) begin
    dataByte <= RxD;
    if ((state == ethRx_pkg::Header) && RxValid)
      hdrShift <= {hdrShift[ShiftW-9:0], RxD};
    if (hdrLast)
      hdr <= {hdrShift, RxD};   // Stays until the next header completes
  end

  // Frames are separated by at least two idle cycles
  assert property (@(posedge RxClk) disable iff (reset) $fell(RxValid) |=> !RxValid)
    else $error("RxValid gap shorter than two cycles");

endmodule

`default_nettype wire

// ==== ethRxTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module ethRxTop (
  input  logic                    RxClk,
  input  logic                    reset,
  input  logic                    RxValid,
  input  ethRx_pkg::byte_t        RxD,
  input  logic                    RxErr,
  input  ethRx_pkg::apbReq_t      apbReq,
  output ethRx_pkg::apbRsp_t      apbRsp,
  output ethRx_pkg::frameResult_t result,
  output logic                    resultValid
);

  ethRx_pkg::frameHdr_t       hdr;
  logic                       hdrDone;
  ethRx_pkg::byte_t           dataByte;
  logic                       dataValid;
  logic                       frameEnd;
  logic                       rxErrSeen;
  logic                       ipv4Bad;
  ethRx_pkg::config_t         cfg;         // From the register block
  logic                       clear;
  ethRx_pkg::macAddr_t        hostMac;     // Learned state
  logic [15:0]                fpgaTable;
  ethRx_pkg::count_t          rxCount;
  ethRx_pkg::count_t          ipErrCount;
  ethRx_pkg::fwdCount_t [2:0] fwdCount;

  ethRxParser i_parser (
    .RxClk, .reset,
    .portActive(cfg.portActive),
    .RxValid, .RxD, .RxErr,
    .hdr, .hdrDone, .dataByte, .dataValid, .frameEnd, .rxErrSeen
  );

  ipv4Checksum i_cksum (
    .RxClk, .reset,
    .start(hdrDone),   // Restart at each new header
    .dataByte, .dataValid, .ipv4Bad
  );

  routeDecision i_route (
    .RxClk, .reset, .cfg, .clear,
    .hdr, .hdrDone, .frameEnd, .ipv4Bad, .rxErrSeen,
    .result, .resultValid, .hostMac, .fpgaTable
  );

  rxCounters i_counters (
    .RxClk, .reset, .clear,
    .result, .resultValid,
    .rxCount, .ipErrCount, .fwdCount
  );

  rxRegs i_regs (
    .RxClk, .reset, .apbReq, .apbRsp,
    .rxCount, .ipErrCount, .fwdCount, .hostMac, .fpgaTable,
    .cfg, .clear
  );

endmodule

`default_nettype wire

// ==== ethRx_consts.svh ====
`ifndef ETHRX_CONSTS_SVH
`define ETHRX_CONSTS_SVH

// Framing
`define ETH_SFD           8'hd5          // Start-of-frame delimiter
`define ETH_HDR_LEN       14             // Dest MAC, source MAC, ethertype

// IPv4 header window, counted from the first payload byte
`define ETH_IPV4_BEGIN    0
`define ETH_IPV4_LEN      20
`define ETH_TYPE_IPV4     16'h0800

// MAC address constants
`define MAC_BROADCAST     48'hffff_ffff_ffff
`define LCSR_CID          24'hfa610e                  // Upper 24 bits of every FPGA MAC
`define LCSR_CID_MCAST    (`LCSR_CID | 24'h010000)    // Group bit set
`define MCAST_LOW_BYTE    8'hff                       // Low byte of board multicast
`define FPGA_PS_MID       16'h0300                    // Middle 16 bits, PS interface
`define FPGA_RT_MID       16'h1394                    // Middle 16 bits, RT interface

// APB register map
`define REG_CTRL          8'h00    // R/W board id and port active
`define REG_CLEAR         8'h04    // W  clear counters and learned state
`define REG_RXCNT         8'h08    // R  frames received
`define REG_IPERR         8'h0C    // R  IPv4 checksum errors
`define REG_FWDCNT        8'h10    // R  forwards per port
`define REG_HOSTHI        8'h14    // R  host MAC [47:16]
`define REG_HOSTLO        8'h18    // R  host MAC [15:0]
`define REG_FPGATAB       8'h1C    // R  FPGA boards behind Eth1

// Register field positions
`define CTRL_ID_MSB       3
`define CTRL_ACTIVE_BIT   4

`endif

// ==== ethRx_pkg.sv ====
`default_nettype none

package ethRx_pkg;

  typedef logic [7:0]  byte_t;      // One received byte
  typedef logic [47:0] macAddr_t;
  typedef logic [3:0]  boardId_t;   // FPGA board id
  typedef logic [2:0]  portMask_t;  // Bit 0 Eth2, bit 1 PS, bit 2 RT
  typedef logic [15:0] count_t;     // Statistics counter
  typedef logic [7:0]  fwdCount_t;  // Per-port forward counter

  // Receive parser states
  typedef enum logic [1:0] {
    Idle,
    Header,
    Data
  } rxState_t;

  // Ethernet header in wire order, first byte in the top bits
  typedef struct packed {
    macAddr_t    destMac;
    macAddr_t    srcMac;
    logic [15:0] etherType;
  } frameHdr_t;

  typedef struct packed {
    portMask_t route;      // Where the frame goes
    logic      ipv4Err;    // Bad IPv4 header checksum
    logic      rxErr;      // RxErr seen during the frame
    logic      broadcast;
    logic      multicast;  // Board multicast
  } frameResult_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apbReq_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apbRsp_t;

  typedef struct packed {
    boardId_t boardId;
    logic     portActive;   // Link up, learning allowed
  } config_t;

endpackage

`default_nettype wire

// ==== ipv4Checksum.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ethRx_consts.svh"

module ipv4Checksum (
  input  logic             RxClk,
  input  logic             reset,
  input  logic             start,
  input  ethRx_pkg::byte_t dataByte,
  input  logic             dataValid,
  output logic             ipv4Bad
);

  localparam logic [5:0] WinFirst = 6'(`ETH_IPV4_BEGIN);
  localparam logic [5:0] WinEnd   = 6'(`ETH_IPV4_BEGIN + `ETH_IPV4_LEN);

  logic [5:0]       byteIdx;   // Payload byte count, stops at WinEnd
  logic [5:0]       winIdx;    // Position inside the IPv4 header
  logic             inWin;
  ethRx_pkg::byte_t hiByte;    // Upper half of the current word
  logic [16:0]      acc;       // Sum, bit 16 is the pending carry

  assign winIdx = byteIdx - WinFirst;
  assign inWin  = (byteIdx >= WinFirst) && (byteIdx < WinEnd);

  // With the carry still pending, ffff shows up as 0ffff or 1fffe
  assign ipv4Bad = (byteIdx < WinEnd) ||
                   !((acc == 17'h0ffff) || (acc == 17'h1fffe));

  always_ff @(posedge RxClk) begin
    if (reset || start) begin
      byteIdx <= '0;
      acc     <= '0;
    end else if (dataValid && (byteIdx < WinEnd)) begin
      byteIdx <= byteIdx + 6'd1;
      if (inWin && winIdx[0])   // Low byte completes a big-endian word
        acc <= {1'b0, acc[15:0]} + {1'b0, hiByte, dataByte} + {16'd0, acc[16]};
    end
  end

  always_ff @(posedge RxClk) begin
    if (dataValid && inWin && !winIdx[0])
      hiByte <= dataByte;
  end

endmodule

`default_nettype wire

// ==== routeDecision.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ethRx_consts.svh"

module routeDecision (
  input  logic                    RxClk,
  input  logic                    reset,
  input  ethRx_pkg::config_t      cfg,
  input  logic                    clear,
  input  ethRx_pkg::frameHdr_t    hdr,
  input  logic                    hdrDone,
  input  logic                    frameEnd,
  input  logic                    ipv4Bad,
  input  logic                    rxErrSeen,
  output ethRx_pkg::frameResult_t result,
  output logic                    resultValid,
  output ethRx_pkg::macAddr_t     hostMac,
  output logic [15:0]             fpgaTable
);

  ethRx_pkg::macAddr_t  psAddr;      // This board's PS address
  ethRx_pkg::macAddr_t  rtAddr;      // This board's RT address
  ethRx_pkg::macAddr_t  dest;
  logic                 isBcast;
  logic                 isMcast;
  logic                 isFpga;      // Some FPGA board
  logic                 fpgaRemote;  // Other board, not known behind Eth1
  logic                 unknownDest;
  ethRx_pkg::portMask_t routeNow;
  ethRx_pkg::portMask_t routeReg;    // Route held for frameEnd

  assign dest   = hdr.destMac;
  assign psAddr = {`LCSR_CID, `FPGA_PS_MID, 4'd0, cfg.boardId};
  assign rtAddr = {`LCSR_CID, `FPGA_RT_MID, 4'd0, cfg.boardId};

  assign isBcast = (dest == `MAC_BROADCAST);
  assign isMcast = (dest[47:24] == `LCSR_CID_MCAST) && (dest[7:0] == `MCAST_LOW_BYTE);
  assign isFpga  = (dest[47:24] == `LCSR_CID);

  assign fpgaRemote  = isFpga && (dest[3:0] != cfg.boardId) && !fpgaTable[dest[3:0]];
  assign unknownDest = (dest != psAddr) && (dest != rtAddr) && !isFpga && (dest != hostMac);

  always_comb begin
    routeNow[0] = isBcast || isMcast || fpgaRemote || unknownDest;   // Eth2
    routeNow[1] = isBcast || isMcast || (dest == psAddr);           // PS
    routeNow[2] = isBcast || isMcast || (dest == rtAddr);           // RT
  end

  // Learning, the route above still sees the old table on this edge
  always_ff @(posedge RxClk) begin
    if (reset || clear || !cfg.portActive) begin
      hostMac   <= `MAC_BROADCAST;
      fpgaTable <= '0;
    end else if (hdrDone) begin
      hostMac <= hdr.srcMac;
      if (hdr.srcMac[47:24] == `LCSR_CID)
        fpgaTable[hdr.srcMac[3:0]] <= 1'b1;   // Board sits behind Eth1
    end
  end

  always_ff @(posedge RxClk) begin
    if (reset)
      resultValid <= 1'b0;
    else
      resultValid <= frameEnd;
  end

  always_ff @(posedge RxClk) begin
    if (hdrDone)
      routeReg <= routeNow;
    if (frameEnd) begin
      result.route     <= routeReg;
      result.ipv4Err   <= ipv4Bad && (hdr.etherType == `ETH_TYPE_IPV4);  // Non-IP ignores it
      result.rxErr     <= rxErrSeen;
      result.broadcast <= isBcast;
      result.multicast <= isMcast;
    end
  end

  // Route taken at hdrDone agrees with the header still held at frameEnd
  assert property (@(posedge RxClk) disable iff (reset)
                   resultValid && result.broadcast |-> (result.route == '1))
    else $error("Broadcast result not sent to every port");

endmodule

`default_nettype wire

// ==== rxCounters.sv ====
`timescale 1ns/1ps
`default_nettype none

module rxCounters (
  input  logic                          RxClk,
  input  logic                          reset,
  input  logic                          clear,
  input  ethRx_pkg::frameResult_t       result,
  input  logic                          resultValid,
  output ethRx_pkg::count_t             rxCount,
  output ethRx_pkg::count_t             ipErrCount,
  output ethRx_pkg::fwdCount_t [2:0]    fwdCount     // Eth2 in [0]
);

  localparam int NumPorts = $bits(ethRx_pkg::portMask_t);

  always_ff @(posedge RxClk) begin
    if (reset || clear) begin
      rxCount    <= '0;
      ipErrCount <= '0;
      fwdCount   <= '0;
    end else if (resultValid) begin
      // All counters stick at full scale
      if (rxCount != '1)
        rxCount <= rxCount + 1'b1;
      if (result.ipv4Err && (ipErrCount != '1))
        ipErrCount <= ipErrCount + 1'b1;
      for (int p = 0; p < NumPorts; p++) begin
        if (result.route[p] && (fwdCount[p] != '1))
          fwdCount[p] <= fwdCount[p] + 1'b1;   // One per port the frame goes to
      end
    end
  end

endmodule

`default_nettype wire

// ==== rxRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ethRx_consts.svh"

module rxRegs (
  input  logic                       RxClk,
  input  logic                       reset,
  input  ethRx_pkg::apbReq_t         apbReq,
  output ethRx_pkg::apbRsp_t         apbRsp,
  input  ethRx_pkg::count_t          rxCount,
  input  ethRx_pkg::count_t          ipErrCount,
  input  ethRx_pkg::fwdCount_t [2:0] fwdCount,
  input  ethRx_pkg::macAddr_t        hostMac,
  input  logic [15:0]                fpgaTable,
  output ethRx_pkg::config_t         cfg,
  output logic                       clear
);

  logic        access;     // APB access phase
  logic        readable;   // Address decodes to a readable register
  logic        writable;
  logic [31:0] rdata;

  assign access = apbReq.psel && apbReq.penable;

  // Address decode and read mux
  always_comb begin
    rdata    = '0;
    readable = 1'b1;
    writable = 1'b0;
    case (apbReq.paddr)
      `REG_CTRL: begin
        rdata    = {27'd0, cfg.portActive, cfg.boardId};
        writable = 1'b1;
      end
      `REG_CLEAR: begin
        readable = 1'b0;   // Command only
        writable = 1'b1;
      end
      `REG_RXCNT:   rdata = {16'd0, rxCount};
      `REG_IPERR:   rdata = {16'd0, ipErrCount};
      `REG_FWDCNT:  rdata = {8'd0, fwdCount};        // RT, PS, Eth2 from the top
      `REG_HOSTHI:  rdata = hostMac[47:16];
      `REG_HOSTLO:  rdata = {16'd0, hostMac[15:0]};
      `REG_FPGATAB: rdata = {16'd0, fpgaTable};
      default:      readable = 1'b0;                 // Unmapped
    endcase
  end

  // No wait states
  assign apbRsp = '{
    prdata:  rdata,
    pready:  access,
    pslverr: access && (apbReq.pwrite ? !writable : !readable)
  };

  always_ff @(posedge RxClk) begin
    if (reset) begin
      cfg   <= '0;
      clear <= 1'b0;
    end else begin
      clear <= access && apbReq.pwrite && (apbReq.paddr == `REG_CLEAR);  // Single pulse
      if (access && apbReq.pwrite && (apbReq.paddr == `REG_CTRL)) begin
        cfg.boardId    <= apbReq.pwdata[`CTRL_ID_MSB:0];
        cfg.portActive <= apbReq.pwdata[`CTRL_ACTIVE_BIT];
      end
    end
  end

  // Access phase always follows a select
  assert property (@(posedge RxClk) disable iff (reset) apbReq.penable |-> apbReq.psel)
    else $error("APB penable without psel");

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
ethRx_pkg.sv
ethRxParser.sv
ipv4Checksum.sv
routeDecision.sv
rxCounters.sv
rxRegs.sv
ethRxTop.sv
tb_ethRx.sv

// ==== tb_ethRx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ethRx_consts.svh"

module tb_ethRx;

  localparam int NumCases = 11;
  localparam int ApbXfers = 32;            // Upper bound on register accesses
  localparam logic [3:0] BoardId = 4'd3;

  // Address kinds for the frame table
  localparam logic [3:0] KBcast = 4'd0;
  localparam logic [3:0] KMcast = 4'd1;
  localparam logic [3:0] KOwnPs = 4'd2;
  localparam logic [3:0] KOwnRt = 4'd3;
  localparam logic [3:0] KRt5   = 4'd4;    // RT interface of board 5
  localparam logic [3:0] KHost  = 4'd5;
  localparam logic [3:0] KFpga5 = 4'd6;    // PS interface of board 5
  localparam logic [3:0] KPc    = 4'd7;

  typedef struct packed {
    logic [3:0]  dest;
    logic [3:0]  src;
    logic [15:0] etherType;
    logic        corrupt;     // Invert one IPv4 header byte
    logic        rxErr;       // RxErr on the last payload byte
    logic [7:0]  payLen;
    logic [2:0]  route;       // Expected, Eth2 in bit 0
    logic        ipErr;
  } frameCase_t;

  logic                    RxClk = 1'b0;
  logic                    reset;
  logic                    RxValid;
  ethRx_pkg::byte_t        RxD;
  logic                    RxErr;
  ethRx_pkg::apbReq_t      apbReq;
  ethRx_pkg::apbRsp_t      apbRsp;
  ethRx_pkg::frameResult_t result;
  logic                    resultValid;

  string caseName [NumCases] = '{"bcast", "mcast", "ownPs", "ownRt", "otherRt", "fpgaSrc",
                                 "knownRt", "unknownHost", "ipBad", "nonIpBad", "ipShort"};
  frameCase_t frameTable [NumCases] = '{
    '{KBcast, KHost,  16'h0800, 1'b0, 1'b0, 8'd46, 3'b111, 1'b0},
    '{KMcast, KHost,  16'h0800, 1'b0, 1'b0, 8'd46, 3'b111, 1'b0},
    '{KOwnPs, KHost,  16'h0800, 1'b0, 1'b0, 8'd46, 3'b010, 1'b0},
    '{KOwnRt, KHost,  16'h0800, 1'b0, 1'b0, 8'd50, 3'b100, 1'b0},
    '{KRt5,   KHost,  16'h0800, 1'b0, 1'b0, 8'd46, 3'b001, 1'b0},   // Board 5 not learned yet
    '{KHost,  KFpga5, 16'h0800, 1'b0, 1'b0, 8'd46, 3'b000, 1'b0},   // Dest is the learned host
    '{KRt5,   KPc,    16'h0800, 1'b0, 1'b0, 8'd46, 3'b000, 1'b0},   // Board 5 behind Eth1 now
    '{KHost,  KPc,    16'h0800, 1'b0, 1'b1, 8'd60, 3'b001, 1'b0},
    '{KBcast, KPc,    16'h0800, 1'b1, 1'b0, 8'd46, 3'b111, 1'b1},
    '{KBcast, KPc,    16'h86dd, 1'b1, 1'b0, 8'd46, 3'b111, 1'b0},   // Not IPv4, sum ignored
    '{KOwnPs, KPc,    16'h0800, 1'b0, 1'b0, 8'd12, 3'b010, 1'b1}    // Short IPv4 header
  };

  // Reference model
  ethRx_pkg::macAddr_t mHost;
  logic [15:0]         mTable;
  int                  mRx;
  int                  mIpErr;
  int                  mFwd [3];

  logic [31:0]      lfsr = 32'hd34acbab;
  ethRx_pkg::byte_t frameQ [$];
  ethRx_pkg::byte_t ipHdr [20];
  int               cycleCount = 0;
  int               cycleLimit;

  always #4 RxClk = ~RxClk;

  ethRxTop i_dut (
    .RxClk, .reset, .RxValid, .RxD, .RxErr,
    .apbReq, .apbRsp, .result, .resultValid
  );

  always @(posedge RxClk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount > cycleLimit) begin
      $display("Timeout, run still going after %0d cycles", cycleCount);
      $display("*** FAILED ***");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Error: %s expected %0h actual %0h", name, exp, act);
      $display("*** FAILED ***");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // Galois form, taps 32 22 2 1
  endfunction

  function automatic ethRx_pkg::byte_t randByte();
    ethRx_pkg::byte_t b;
    b = '0;
    for (int k = 0; k < 8; k++) begin
      b    = {b[6:0], lfsr[0]};   // One step per bit
      lfsr = lfsrStep(lfsr);
    end
    return b;
  endfunction

  function automatic ethRx_pkg::macAddr_t macOf(input logic [3:0] kind);
    case (kind)
      KBcast:  return `MAC_BROADCAST;
      KMcast:  return {`LCSR_CID_MCAST, 16'h0000, 8'hff};
      KOwnPs:  return {`LCSR_CID, `FPGA_PS_MID, 4'd0, BoardId};
      KOwnRt:  return {`LCSR_CID, `FPGA_RT_MID, 4'd0, BoardId};
      KRt5:    return {`LCSR_CID, `FPGA_RT_MID, 8'h05};
      KHost:   return 48'h0002_b3aa_1122;
      KFpga5:  return {`LCSR_CID, `FPGA_PS_MID, 8'h05};
      default: return 48'h0050_56c0_0001;
    endcase
  endfunction

  // Forwarding rules against the model's table before this frame
  function automatic ethRx_pkg::portMask_t modelRoute(input ethRx_pkg::macAddr_t dest);
    logic                 group;   // Broadcast or board multicast
    logic                 fpga;
    ethRx_pkg::portMask_t r;
    group = (dest == `MAC_BROADCAST) ||
            ((dest[47:24] == `LCSR_CID_MCAST) && (dest[7:0] == 8'hff));
    fpga  = (dest[47:24] == `LCSR_CID);
    r[1]  = group || (dest == {`LCSR_CID, `FPGA_PS_MID, 4'd0, BoardId});
    r[2]  = group || (dest == {`LCSR_CID, `FPGA_RT_MID, 4'd0, BoardId});
    r[0]  = group || (fpga && (dest[3:0] != BoardId) && !mTable[dest[3:0]]) ||
            (!fpga && (dest != mHost));
    return r;
  endfunction

  // IPv4 header with a correct checksum, then optionally spoiled
  task automatic buildIpHeader(input int id, input int totalLen, input logic corrupt);
    logic [159:0] h;
    logic [16:0]  sum;
    h   = {8'h45, 8'h00, 16'(totalLen), 16'(id), 16'h4000, 8'h40, 8'h11, 16'h0000,
           32'hc0a8_0001, 32'hc0a8_00c7};
    sum = '0;
    for (int w = 0; w < 10; w++)
      sum = {1'b0, sum[15:0]} + {1'b0, h[159-16*w -: 16]} + {16'd0, sum[16]};
    sum = {1'b0, sum[15:0]} + {16'd0, sum[16]};   // Fold the last carry
    h[79:64] = ~sum[15:0];
    for (int i = 0; i < 20; i++)
      ipHdr[i] = h[159-8*i -: 8];
    if (corrupt)
      ipHdr[12] = ~ipHdr[12];
  endtask

  task automatic sendCase(input int idx, input logic active, input logic useTable);
    frameCase_t           c;
    ethRx_pkg::macAddr_t  dest;
    ethRx_pkg::macAddr_t  src;
    logic [111:0]         hdrBits;
    ethRx_pkg::portMask_t expRoute;
    logic                 expErr;
    c        = frameTable[idx];
    dest     = macOf(c.dest);
    src      = macOf(c.src);
    hdrBits  = {dest, src, c.etherType};
    expRoute = modelRoute(dest);
    expErr   = (c.etherType == `ETH_TYPE_IPV4) &&
               (c.corrupt || (int'(c.payLen) < `ETH_IPV4_LEN));
    if (active) begin
      mHost = src;                        // Learn after the route is known
      if (src[47:24] == `LCSR_CID)
        mTable[src[3:0]] = 1'b1;
      mRx    += 1;
      mIpErr += int'(expErr);
      for (int p = 0; p < 3; p++)
        mFwd[p] += int'(expRoute[p]);
    end
    buildIpHeader(idx, int'(c.payLen), c.corrupt);
    frameQ.delete();
    repeat (7) frameQ.push_back(8'h55);   // Preamble
    frameQ.push_back(`ETH_SFD);
    for (int i = 0; i < `ETH_HDR_LEN; i++)
      frameQ.push_back(hdrBits[111-8*i -: 8]);
    for (int i = 0; i < int'(c.payLen); i++) begin
      if (i < `ETH_IPV4_LEN)
        frameQ.push_back(ipHdr[i]);
      else
        frameQ.push_back(randByte());     // Filler
    end
    foreach (frameQ[i]) begin
      @(posedge RxClk);
      RxValid <= 1'b1;
      RxD     <= frameQ[i];
      RxErr   <= c.rxErr && (i == frameQ.size() - 1);   // Must stick until the result
    end
    @(posedge RxClk);
    RxValid <= 1'b0;
    RxD     <= '0;
    RxErr   <= 1'b0;
    if (active) begin
      // Result comes exactly 2 cycles after the first idle sample
      @(posedge RxClk);
      @(negedge RxClk);
      checkValue({caseName[idx], " early resultValid"}, 32'(1'b0), 32'(resultValid));
      @(posedge RxClk);
      @(negedge RxClk);
      checkValue({caseName[idx], " resultValid"}, 32'(1'b1), 32'(resultValid));
      checkValue({caseName[idx], " route"}, 32'(expRoute), 32'(result.route));
      checkValue({caseName[idx], " ipv4Err"}, 32'(expErr), 32'(result.ipv4Err));
      checkValue({caseName[idx], " broadcast"}, 32'(c.dest == KBcast), 32'(result.broadcast));
      checkValue({caseName[idx], " multicast"}, 32'(c.dest == KMcast), 32'(result.multicast));
      checkValue({caseName[idx], " rxErr"}, 32'(c.rxErr), 32'(result.rxErr));
      if (useTable) begin
        checkValue({caseName[idx], " table route"}, 32'(c.route), 32'(result.route));
        checkValue({caseName[idx], " table ipv4Err"}, 32'(c.ipErr), 32'(result.ipv4Err));
      end
    end else begin
      repeat (6) begin
        @(negedge RxClk);
        checkValue({caseName[idx], " inactive resultValid"}, 32'(1'b0), 32'(resultValid));
      end
    end
  endtask

  task automatic apbXfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                         output logic [31:0] rdata, output logic slverr);
    @(posedge RxClk);
    apbReq <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge RxClk);
    apbReq.penable <= 1'b1;               // Access cycle
    @(negedge RxClk);
    checkValue("APB pready", 32'(1'b1), 32'(apbRsp.pready));
    rdata  = apbRsp.prdata;
    slverr = apbRsp.pslverr;
    @(posedge RxClk);
    apbReq <= '0;
  endtask

  task automatic regWrite(input string name, input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apbXfer(1'b1, addr, data, rd, err);
    checkValue({name, " pslverr"}, 32'(1'b0), 32'(err));
  endtask

  task automatic regRead(input string name, input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    logic        err;
    apbXfer(1'b0, addr, 32'd0, rd, err);
    checkValue({name, " pslverr"}, 32'(1'b0), 32'(err));
    checkValue(name, exp, rd);
  endtask

  task automatic regError(input string name, input logic wr, input logic [7:0] addr);
    logic [31:0] rd;
    logic        err;
    apbXfer(wr, addr, 32'h1234_5678, rd, err);
    checkValue({name, " pslverr"}, 32'(1'b1), 32'(err));
  endtask

  initial begin
    int frameCycles;
    RxValid = 1'b0;
    RxD     = '0;
    RxErr   = 1'b0;
    apbReq  = '0;
    reset   = 1'b1;
    mHost   = `MAC_BROADCAST;
    mTable  = '0;
    mRx     = 0;
    mIpErr  = 0;
    mFwd    = '{0, 0, 0};
    frameCycles = 0;
    for (int i = 0; i < NumCases; i++)
      frameCycles += 8 + `ETH_HDR_LEN + int'(frameTable[i].payLen) + 6;
    frameCycles += 2 * (8 + `ETH_HDR_LEN + int'(frameTable[0].payLen) + 6);   // Late frames
    cycleLimit = 2 * (frameCycles + 4 * ApbXfers + 2);
    repeat (2) @(posedge RxClk);
    reset <= 1'b0;

    regWrite("ctrl write", `REG_CTRL, {27'd0, 1'b1, BoardId});
    regRead("ctrl readback", `REG_CTRL, {27'd0, 1'b1, BoardId});
    regError("rxcnt write", 1'b1, `REG_RXCNT);
    regError("unmapped read", 1'b0, 8'h20);
    regError("clear read", 1'b0, `REG_CLEAR);

    for (int i = 0; i < NumCases; i++)
      sendCase(i, 1'b1, 1'b1);

    regRead("rx count", `REG_RXCNT, 32'(mRx));
    regRead("ipv4 errors", `REG_IPERR, 32'(mIpErr));
    regRead("forward counts", `REG_FWDCNT, {8'd0, 8'(mFwd[2]), 8'(mFwd[1]), 8'(mFwd[0])});
    regRead("host high", `REG_HOSTHI, mHost[47:16]);
    regRead("host low", `REG_HOSTLO, {16'd0, mHost[15:0]});
    regRead("fpga table", `REG_FPGATAB, {16'd0, mTable});

    // Clear wipes counters and learned state
    regWrite("clear write", `REG_CLEAR, 32'hffff_ffff);
    mHost  = `MAC_BROADCAST;
    mTable = '0;
    mRx    = 0;
    mIpErr = 0;
    mFwd   = '{0, 0, 0};
    regRead("rx count cleared", `REG_RXCNT, 32'd0);
    regRead("ipv4 errors cleared", `REG_IPERR, 32'd0);
    regRead("forward counts cleared", `REG_FWDCNT, 32'd0);
    regRead("fpga table cleared", `REG_FPGATAB, 32'd0);
    regRead("host high cleared", `REG_HOSTHI, 32'hffff_ffff);

    sendCase(0, 1'b1, 1'b0);              // Relearn a host
    regRead("host low relearned", `REG_HOSTLO, {16'd0, mHost[15:0]});

    // Port inactive holds learning cleared and drops frames
    regWrite("ctrl inactive", `REG_CTRL, {28'd0, BoardId});
    mHost  = `MAC_BROADCAST;
    mTable = '0;
    regRead("host high inactive", `REG_HOSTHI, 32'hffff_ffff);
    regRead("host low inactive", `REG_HOSTLO, 32'h0000_ffff);
    sendCase(0, 1'b0, 1'b0);
    regRead("rx count inactive", `REG_RXCNT, 32'(mRx));

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
